// File: src/fetch_pkg.sv
package fetch_pkg;

    // datapath width, one instruction per word
    localparam int word_width = 16;

    // address split is tag | index | offset
    localparam int tag_width = 12;
    localparam int index_width = 2;
    localparam int offset_width = 2;

    // cache geometry
    localparam int line_words = 4;
    localparam int num_sets = 4;

    // read strobe to data strobe, in cycles
    localparam int mem_latency = 3;

    // rom size in words, addresses wrap at this depth
    localparam int mem_depth = 256;

    // instruction and data words
    typedef logic [word_width-1:0] word_t;
    // word addresses
    typedef logic [word_width-1:0] addr_t;
    // address fields
    typedef logic [tag_width-1:0] tag_t;
    typedef logic [index_width-1:0] index_t;
    typedef logic [offset_width-1:0] offset_t;

    // one cache block, valid bit on top
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t data;
    } line_entry_t;

    // cache to memory read strobe
    typedef struct packed {
        logic  read;
        addr_t addr;
    } mem_req_t;

    // memory to cache data strobe
    typedef struct packed {
        logic  valid;
        word_t data;
    } mem_rsp_t;

    // cache controller states
    typedef enum logic [1:0] {
        idle,
        lookup,
        refill,
        respond
    } cache_state_t;

    // fetch unit states
    typedef enum logic {
        run,
        wait_rsp
    } fetch_state_t;

endpackage

// File: src/inst_mem.sv
`timescale 1ns/1ps

module inst_mem (
    input  logic                clk,
    input  logic                rst_n,
    input  fetch_pkg::mem_req_t mem_req,
    output fetch_pkg::mem_rsp_t mem_rsp
);
    import fetch_pkg::*;

    // program image
    word_t    rom [mem_depth];

    // read strobe and address per stage
    // stage 0 is loaded on the cycle of the read
    mem_req_t pipe [mem_latency];

    initial begin
        $readmemh("program.hex", rom);
    end

    // latency pipeline, several reads may be in flight
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < mem_latency; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= mem_req;
            for (int i = 1; i < mem_latency; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    // rom read at the pipeline end
    // address wraps at the image size
    always_comb begin
        mem_rsp.valid = pipe[mem_latency-1].read;
        mem_rsp.data  = rom[pipe[mem_latency-1].addr % mem_depth];
    end

endmodule

// File: src/icache.sv
`timescale 1ns/1ps

module icache (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req,
    input  fetch_pkg::addr_t    req_addr,
    output logic                rsp,
    output fetch_pkg::word_t    rsp_data,
    output logic                rsp_hit,
    output fetch_pkg::mem_req_t mem_req,
    input  fetch_pkg::mem_rsp_t mem_rsp
);
    import fetch_pkg::*;

    // block storage, one entry per set and word
    line_entry_t  cache_mem [num_sets][line_words];

    cache_state_t state;

    // request address, held for the whole transaction
    addr_t        lat_addr;
    tag_t         lat_tag;
    index_t       lat_index;
    offset_t      lat_offset;

    // block addressed by the latched request
    line_entry_t  sel_entry;
    logic         hit;

    // refill read issue
    logic         issue;
    logic         issue_on;
    offset_t      issue_cnt;

    // refill write position
    offset_t      fill_cnt;

    // field split of the latched address
    assign lat_tag    = lat_addr[word_width-1 -: tag_width];
    assign lat_index  = lat_addr[offset_width +: index_width];
    assign lat_offset = lat_addr[offset_width-1:0];

    // tag compare against the addressed block
    assign sel_entry = cache_mem[lat_index][lat_offset];
    assign hit       = sel_entry.valid && (sel_entry.tag == lat_tag);

    // first read goes out in lookup on a miss
    // the other three follow back to back in refill
    assign issue = ((state == lookup) && !hit) || ((state == refill) && issue_on);

    // line base plus word counter
    always_comb begin
        mem_req.read = issue;
        mem_req.addr = {lat_tag, lat_index, issue_cnt};
    end

    // hit answers straight from lookup
    // miss answers one cycle after the last word lands
    assign rsp      = ((state == lookup) && hit) || (state == respond);
    assign rsp_hit  = (state == lookup);
    assign rsp_data = sel_entry.data;

    // request address capture
    always_ff @(posedge clk) begin
        if (req) begin
            lat_addr <= req_addr;
        end
    end

    // controller
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= idle;
            issue_on  <= 1'b0;
            issue_cnt <= '0;
            fill_cnt  <= '0;
        end else begin
            // read counter wraps back to 0 after the fourth read
            if (issue) begin
                issue_cnt <= issue_cnt + 1'b1;
                issue_on  <= (issue_cnt != offset_t'(line_words - 1));
            end

            // one block per data strobe, in order
            if (mem_rsp.valid) begin
                fill_cnt <= fill_cnt + 1'b1;
            end

            case (state)
                idle: begin
                    if (req) begin
                        state <= lookup;
                    end
                end
                lookup: begin
                    state <= hit ? idle : refill;
                end
                refill: begin
                    // last word of the line
                    if (mem_rsp.valid && (fill_cnt == offset_t'(line_words - 1))) begin
                        state <= respond;
                    end
                end
                respond: begin
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // block array, only the valid bits clear on reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                for (int b = 0; b < line_words; b++) begin
                    cache_mem[s][b].valid <= 1'b0;
                end
            end
        end else if (mem_rsp.valid && (state == refill)) begin
            cache_mem[lat_index][fill_cnt] <= '{valid: 1'b1, tag: lat_tag, data: mem_rsp.data};
        end
    end

    // memory answers only to reads this controller issued
    a_mem_rsp_in_refill: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_rsp.valid |-> (state == refill)
    );

    // one response per request
    a_rsp_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp |=> !rsp
    );

    // fetch unit keeps a single fetch outstanding
    a_req_in_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        req |-> (state == idle)
    );

endmodule

// File: src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             redirect,
    input  fetch_pkg::addr_t target,
    input  logic             stall,
    output logic             req,
    output fetch_pkg::addr_t req_addr,
    input  logic             rsp,
    input  fetch_pkg::word_t rsp_data,
    input  logic             rsp_hit,
    output fetch_pkg::word_t instr,
    output fetch_pkg::addr_t instr_pc,
    output logic             instr_valid,
    output logic             instr_hit
);
    import fetch_pkg::*;

    fetch_state_t state;

    // next address to fetch
    addr_t        pc;

    // redirect seen while a fetch was in flight
    logic         cancel;

    logic         drop;
    logic         accept;
    logic         issue;

    // a redirect on the response cycle also kills it
    assign drop   = cancel | redirect;
    assign accept = (state == wait_rsp) && rsp && !drop;

    // decide in run, req goes out one cycle later
    assign issue  = (state == run) && !req && !stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= run;
            req         <= 1'b0;
            pc          <= '0;
            cancel      <= 1'b0;
            instr_valid <= 1'b0;
        end else begin
            req         <= issue;
            instr_valid <= accept;

            case (state)
                run: begin
                    if (req) begin
                        state <= wait_rsp;
                    end
                end
                wait_rsp: begin
                    if (rsp) begin
                        state <= run;
                    end
                end
                default: begin
                    state <= run;
                end
            endcase

            // in flight from the req cycle until rsp
            if (rsp) begin
                cancel <= 1'b0;
            end else if (redirect && (req || (state == wait_rsp))) begin
                cancel <= 1'b1;
            end

            // redirect wins over sequential advance
            if (redirect) begin
                pc <= target;
            end else if (accept) begin
                pc <= req_addr + 1'b1;
            end
        end
    end

    // request address and delivered instruction
    always_ff @(posedge clk) begin
        if (issue) begin
            req_addr <= redirect ? target : pc;
        end
        if (accept) begin
            instr     <= rsp_data;
            instr_pc  <= req_addr;
            instr_hit <= rsp_hit;
        end
    end

    // one fetch outstanding at a time
    a_no_req_in_wait: assert property (
        @(posedge clk) disable iff (!rst_n)
        req |-> (state != wait_rsp)
    );

    // cache answers only a fetch that is waiting
    a_rsp_when_waiting: assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp |-> (state == wait_rsp)
    );

endmodule

// File: src/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             redirect,
    input  fetch_pkg::addr_t target,
    input  logic             stall,
    output fetch_pkg::word_t instr,
    output fetch_pkg::addr_t instr_pc,
    output logic             instr_valid,
    output logic             instr_hit
);
    import fetch_pkg::*;

    // fetch unit to cache
    logic     req;
    addr_t    req_addr;
    logic     rsp;
    word_t    rsp_data;
    logic     rsp_hit;

    // cache to memory
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    // pc, redirect, stall and instruction register
    fetch_unit fetch_unit_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .redirect    (redirect),
        .target      (target),
        .stall       (stall),
        .req         (req),
        .req_addr    (req_addr),
        .rsp         (rsp),
        .rsp_data    (rsp_data),
        .rsp_hit     (rsp_hit),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .instr_valid (instr_valid),
        .instr_hit   (instr_hit)
    );

    // direct mapped, line refill on miss
    icache icache_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .req_addr (req_addr),
        .rsp      (rsp),
        .rsp_data (rsp_data),
        .rsp_hit  (rsp_hit),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp)
    );

    // fixed latency program rom
    inst_mem inst_mem_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

endmodule

// File: bench/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;
    import fetch_pkg::*;

    localparam int reset_cycles = 8;
    // miss is req to instr_valid in mem_latency + 6, req may sit in the first stall cycle
    localparam int stall_drain = mem_latency + 7;
    // req, rsp, then instr_valid with the next req
    localparam int hit_gap = 3;
    localparam int depth_bits = $clog2(mem_depth);
    localparam int random_cycles = 400;
    localparam int num_fetches = 90;
    localparam int clean_redirects = 7;
    localparam int stall_rounds = 4;
    localparam int cycle_limit = num_fetches * (mem_latency + 8) + random_cycles
        + clean_redirects * (stall_drain + 2) + stall_rounds * (stall_drain + 17)
        + reset_cycles + 200;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        redirect;
    addr_t       target;
    logic        stall;
    word_t       instr;
    addr_t       instr_pc;
    logic        instr_valid;
    logic        instr_hit;

    // program image and tag model
    word_t       rom_ref [mem_depth];
    logic        valid_ref [num_sets];
    tag_t        tag_ref [num_sets];
    // set that a cancelled fetch may have refilled
    logic        unknown_set [num_sets];

    addr_t       exp_pc;
    logic        after_redirect;
    logic        clean_run;
    logic        have_prev;
    int          prev_cycle;
    int          stall_cnt;
    int          cycle_no = 0;
    int          delivered = 0;
    int          err_count = 0;
    int          test_count = 0;
    int          test_del0;
    int          test_err0;
    logic [31:0] lfsr_state = 32'h1532_c699;

    fetch_top fetch_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .redirect    (redirect),
        .target      (target),
        .stall       (stall),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .instr_valid (instr_valid),
        .instr_hit   (instr_hit)
    );

    always #4 clk = ~clk;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    task automatic wait_deliveries(input int n);
        int goal;
        goal = delivered + n;
        while (delivered < goal) begin
            @(posedge clk);
        end
    endtask

    // stall until nothing is in flight, then redirect
    task automatic clean_redirect(input addr_t dest);
        stall <= 1'b1;
        repeat (stall_drain + 1) @(posedge clk);
        redirect <= 1'b1;
        target <= dest;
        @(posedge clk);
        redirect <= 1'b0;
        stall <= 1'b0;
    endtask

    task automatic start_test();
        test_del0 = delivered;
        test_err0 = err_count;
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %-10s %0d delivered, %0d errors", name,
                 delivered - test_del0, err_count - test_err0);
    endtask

    // outputs are sampled mid cycle
    always @(negedge clk) begin : check_outputs
        index_t set_i;
        tag_t   tag_i;
        logic   exp_hit;
        word_t  exp_word;
        cycle_no = cycle_no + 1;
        if (!rst_n) begin
            exp_pc = '0;
            after_redirect = 1'b0;
            clean_run = 1'b0;
            have_prev = 1'b0;
            prev_cycle = 0;
            stall_cnt = 0;
            for (int s = 0; s < num_sets; s++) begin
                valid_ref[s] = 1'b0;
                tag_ref[s] = '0;
                unknown_set[s] = 1'b0;
            end
        end else begin
            stall_cnt = stall ? stall_cnt + 1 : 0;
            if (instr_valid) begin
                delivered = delivered + 1;
                exp_word = rom_ref[instr_pc[depth_bits-1:0]];
                assert (instr === exp_word) else begin
                    err_count++;
                    $display("error: instr = %h, expected %h at instr_pc %h",
                             instr, exp_word, instr_pc);
                end
                assert (instr_pc === exp_pc) else begin
                    err_count++;
                    if (after_redirect) begin
                        $display("error: instr_pc = %h after redirect, expected target %h",
                                 instr_pc, exp_pc);
                    end else begin
                        $display("error: instr_pc = %h, expected %h", instr_pc, exp_pc);
                    end
                end
                // direct mapped lookup on the model
                set_i = instr_pc[offset_width +: index_width];
                tag_i = instr_pc[word_width-1 -: tag_width];
                exp_hit = valid_ref[set_i] && (tag_ref[set_i] == tag_i);
                if (!unknown_set[set_i]) begin
                    assert (instr_hit === exp_hit) else begin
                        err_count++;
                        $display("error: instr_hit = %h, expected %h at instr_pc %h",
                                 instr_hit, exp_hit, instr_pc);
                    end
                    if (have_prev && clean_run && exp_hit) begin
                        assert (cycle_no - prev_cycle == hit_gap) else begin
                            err_count++;
                            $display("hit came %0d cycles after the previous one, not %0d",
                                     cycle_no - prev_cycle, hit_gap);
                        end
                    end
                end
                assert (stall_cnt <= stall_drain) else begin
                    err_count++;
                    $display("instruction delivered while stall was held for %0d cycles",
                             stall_cnt);
                end
                valid_ref[set_i] = 1'b1;
                tag_ref[set_i] = tag_i;
                unknown_set[set_i] = 1'b0;
                have_prev = 1'b1;
                prev_cycle = cycle_no;
                clean_run = 1'b1;
                exp_pc = instr_pc + 1'b1;
                after_redirect = 1'b0;
            end
            clean_run = clean_run && !stall && !redirect;
            if (redirect) begin
                // the fetch in flight still refills its line
                if (stall_cnt <= stall_drain) begin
                    unknown_set[exp_pc[offset_width +: index_width]] = 1'b1;
                end
                exp_pc = target;
                after_redirect = 1'b1;
            end
        end
    end

    initial begin : watchdog
        while (cycle_no <= cycle_limit) begin
            @(posedge clk);
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Something failed");
        $finish;
    end

    initial begin : run_tests
        logic [31:0] bits;
        addr_t       base;
        rst_n <= 1'b0;
        redirect <= 1'b0;
        target <= '0;
        stall <= 1'b0;
        $readmemh("program.hex", rom_ref);
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;

        // cold cache, first word of each line misses
        start_test();
        wait_deliveries(16);
        end_test("sequential");

        // same words again, back to back hits
        start_test();
        clean_redirect(addr_t'(0));
        wait_deliveries(16);
        end_test("hit run");

        // two lines 16 words apart share a set
        start_test();
        take_bits(8, bits);
        base = addr_t'(bits[7:0]);
        for (int r = 0; r < clean_redirects - 1; r++) begin
            clean_redirect(r[0] ? base ^ addr_t'(16) : base);
            wait_deliveries(3);
        end
        end_test("conflict");

        // next fetch already out when the redirect lands
        start_test();
        for (int r = 0; r < 6; r++) begin
            wait_deliveries(2);
            take_bits(8, bits);
            redirect <= 1'b1;
            target <= addr_t'(bits[7:0]);
            @(posedge clk);
            redirect <= 1'b0;
        end
        wait_deliveries(2);
        end_test("redirect");

        start_test();
        for (int r = 0; r < stall_rounds; r++) begin
            wait_deliveries(4);
            stall <= 1'b1;
            take_bits(4, bits);
            repeat (stall_drain + 2 + int'(bits[3:0])) @(posedge clk);
            stall <= 1'b0;
        end
        wait_deliveries(4);
        end_test("stall");

        // stall one cycle in four, redirect one in sixteen
        start_test();
        repeat (random_cycles) begin
            @(posedge clk);
            take_bits(2, bits);
            stall <= (bits[1:0] == 2'b00);
            take_bits(4, bits);
            redirect <= (bits[3:0] == 4'h0);
            if (bits[3:0] == 4'h0) begin
                take_bits(8, bits);
                target <= addr_t'(bits[7:0]);
            end
        end
        @(posedge clk);
        stall <= 1'b0;
        redirect <= 1'b0;
        wait_deliveries(4);
        end_test("random");

        $display("total: %0d tests, %0d delivered, %0d errors", test_count, delivered, err_count);
        if (err_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: program.hex
// one 16-bit word per entry from address 0, 16 per line, word is {~addr, addr}
ff00 fe01 fd02 fc03 fb04 fa05 f906 f807 f708 f609 f50a f40b f30c f20d f10e f00f
ef10 ee11 ed12 ec13 eb14 ea15 e916 e817 e718 e619 e51a e41b e31c e21d e11e e01f
df20 de21 dd22 dc23 db24 da25 d926 d827 d728 d629 d52a d42b d32c d22d d12e d02f
cf30 ce31 cd32 cc33 cb34 ca35 c936 c837 c738 c639 c53a c43b c33c c23d c13e c03f
bf40 be41 bd42 bc43 bb44 ba45 b946 b847 b748 b649 b54a b44b b34c b24d b14e b04f
af50 ae51 ad52 ac53 ab54 aa55 a956 a857 a758 a659 a55a a45b a35c a25d a15e a05f
9f60 9e61 9d62 9c63 9b64 9a65 9966 9867 9768 9669 956a 946b 936c 926d 916e 906f
8f70 8e71 8d72 8c73 8b74 8a75 8976 8877 8778 8679 857a 847b 837c 827d 817e 807f
7f80 7e81 7d82 7c83 7b84 7a85 7986 7887 7788 7689 758a 748b 738c 728d 718e 708f
6f90 6e91 6d92 6c93 6b94 6a95 6996 6897 6798 6699 659a 649b 639c 629d 619e 609f
5fa0 5ea1 5da2 5ca3 5ba4 5aa5 59a6 58a7 57a8 56a9 55aa 54ab 53ac 52ad 51ae 50af
4fb0 4eb1 4db2 4cb3 4bb4 4ab5 49b6 48b7 47b8 46b9 45ba 44bb 43bc 42bd 41be 40bf
3fc0 3ec1 3dc2 3cc3 3bc4 3ac5 39c6 38c7 37c8 36c9 35ca 34cb 33cc 32cd 31ce 30cf
2fd0 2ed1 2dd2 2cd3 2bd4 2ad5 29d6 28d7 27d8 26d9 25da 24db 23dc 22dd 21de 20df
1fe0 1ee1 1de2 1ce3 1be4 1ae5 19e6 18e7 17e8 16e9 15ea 14eb 13ec 12ed 11ee 10ef
0ff0 0ef1 0df2 0cf3 0bf4 0af5 09f6 08f7 07f8 06f9 05fa 04fb 03fc 02fd 01fe 00ff

// File: build.f
src/fetch_pkg.sv
src/inst_mem.sv
src/icache.sv
src/fetch_unit.sv
src/fetch_top.sv
bench/fetch_tb.sv

// File: Makefile
# Verilator build and run of the fetch testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb -f build.f -o fetch_tb

# pass only if the testbench printed the pass line
run: compile
	out=$$(./obj_dir/fetch_tb); echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
